/* hdl/soc_dbus_consts.svh */
`ifndef SOC_DBUS_CONSTS_SVH
`define SOC_DBUS_CONSTS_SVH

// Bus widths
`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_BE_W        4

// Main RAM window is word addressed inside the RAM
`define SOC_RAM_BASE    32'h0000_0000
`define SOC_RAM_WORDS   1024
`define SOC_RAM_ADDR_W  10
`define SOC_RAM_BYTES   (`SOC_RAM_WORDS * 4)

// GPIO register window
`define SOC_GPIO_BASE   32'h1000_0000
`define SOC_GPIO_BYTES  32'h0000_0100

`endif

/* hdl/soc_dbus_pkg.sv */
`include "soc_dbus_consts.svh"

package soc_dbus_pkg;

    // One data word taken either whole or lane by lane
    typedef union packed {
        logic [`SOC_DATA_W-1:0]    word;
        logic [`SOC_BE_W-1:0][7:0] bytes;
    } bus_word_u;

    // Which slave an address falls into
    typedef enum logic [1:0] {
        RAM,
        GPIO,
        NONE
    } dbus_region_e;

endpackage

/* hdl/slave_bus_if.sv */
`include "soc_dbus_consts.svh"

interface slave_bus_if;

    logic [`SOC_ADDR_W-1:0] address;  // Offset inside the slave window
    logic [`SOC_DATA_W-1:0] wrdata;
    logic [`SOC_BE_W-1:0]   byteenable;
    logic                   read;
    logic                   write;
    logic [`SOC_DATA_W-1:0] rddata;
    logic                   stall;    // Master holds its request while high

    modport master (
        output address, wrdata, byteenable, read, write,
        input  rddata, stall
    );

    modport slave (
        input  address, wrdata, byteenable, read, write,
        output rddata, stall
    );

endinterface

/* hdl/mem_if.sv */
`include "soc_dbus_consts.svh"

interface mem_if;

    logic [`SOC_RAM_ADDR_W-1:0] addr;   // Word address
    logic [`SOC_DATA_W-1:0]     wrdata;
    logic                       read;
    logic                       write;
    logic [`SOC_DATA_W-1:0]     rddata; // Valid one cycle after read

    modport ctrl (
        output addr, wrdata, read, write,
        input  rddata
    );

    modport mem (
        input  addr, wrdata, read, write,
        output rddata
    );

endinterface

/* hdl/dbus.sv */
`include "soc_dbus_consts.svh"

module dbus (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [`SOC_ADDR_W-1:0] master_address_i,
    input  logic [`SOC_BE_W-1:0]   master_byteenable_i,
    input  logic                   master_read_i,
    input  logic                   master_write_i,
    input  logic [`SOC_DATA_W-1:0] master_wrdata_i,
    output logic [`SOC_DATA_W-1:0] master_rddata_o,
    output logic                   master_stall_o,
    slave_bus_if.master            ram_bus,
    slave_bus_if.master            gpio_bus
);
    import soc_dbus_pkg::*;

    dbus_region_e           region;
    logic [`SOC_ADDR_W-1:0] ram_off;
    logic [`SOC_ADDR_W-1:0] gpio_off;

    // Unsigned distance from each base, so one compare checks both bounds
    assign ram_off  = master_address_i - `SOC_RAM_BASE;
    assign gpio_off = master_address_i - `SOC_GPIO_BASE;

    always_comb begin
        if (ram_off < `SOC_RAM_BYTES) begin
            region = RAM;
        end else if (gpio_off < `SOC_GPIO_BYTES) begin
            region = GPIO;
        end else begin
            region = NONE;
        end
    end

    assign ram_bus.address    = ram_off;
    assign ram_bus.wrdata     = master_wrdata_i;
    assign ram_bus.byteenable = master_byteenable_i;
    assign ram_bus.read       = master_read_i && (region == RAM);
    assign ram_bus.write      = master_write_i && (region == RAM);

    assign gpio_bus.address    = gpio_off;
    assign gpio_bus.wrdata     = master_wrdata_i;
    assign gpio_bus.byteenable = master_byteenable_i;
    assign gpio_bus.read       = master_read_i && (region == GPIO);
    assign gpio_bus.write      = master_write_i && (region == GPIO);

    always_comb begin
        case (region)
            RAM: begin
                master_rddata_o = ram_bus.rddata;
                master_stall_o  = ram_bus.stall;
            end
            GPIO: begin
                master_rddata_o = gpio_bus.rddata;
                master_stall_o  = gpio_bus.stall;
            end
            default: begin
                master_rddata_o = '0;  // Unmapped reads return zero
                master_stall_o  = 1'b0;
            end
        endcase
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(master_read_i && master_write_i));

    // A stalled access must not wander to another slave
    a_region_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        master_stall_o |=> region == $past(region));

endmodule

/* hdl/bytes_conv.sv */
`include "soc_dbus_consts.svh"

module bytes_conv (
    input  logic       clk,
    input  logic       arst_n_i,
    slave_bus_if.slave bus,
    mem_if.ctrl        mem
);
    import soc_dbus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_MERGE
    } state_e;

    state_e    state_q;
    state_e    state_d;
    bus_word_u fetched;
    bus_word_u wr_word;
    bus_word_u merged;
    logic      full_word;

    assign full_word = (bus.byteenable == {`SOC_BE_W{1'b1}});
    assign fetched   = mem.rddata;  // Held in the RAM output register
    assign wr_word   = bus.wrdata;

    always_comb begin
        merged = fetched;
        for (int i = 0; i < `SOC_BE_W; i++) begin
            if (bus.byteenable[i]) begin
                merged.bytes[i] = wr_word.bytes[i];
            end
        end
    end

    assign mem.addr    = bus.address[`SOC_RAM_ADDR_W+1:2];
    assign bus.rddata  = fetched.word;

    always_comb begin
        state_d    = state_q;
        mem.read   = 1'b0;
        mem.write  = 1'b0;
        mem.wrdata = wr_word.word;
        bus.stall  = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (bus.read) begin
                    mem.read  = 1'b1;
                    bus.stall = 1'b1;
                    state_d   = ST_READ;
                end else if (bus.write) begin
                    if (full_word) begin
                        mem.write = 1'b1;  // Whole word goes straight through
                    end else begin
                        mem.read  = 1'b1;
                        bus.stall = 1'b1;
                        state_d   = ST_READ;
                    end
                end
            end
            ST_READ: begin
                // Old word is on mem.rddata now
                if (bus.write) begin
                    mem.write  = 1'b1;
                    mem.wrdata = merged.word;
                    bus.stall  = 1'b1;
                    state_d    = ST_MERGE;
                end else begin
                    state_d = ST_IDLE;
                end
            end
            ST_MERGE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        bus.stall |=> $stable(bus.address) && $stable(bus.wrdata)
                      && $stable(bus.byteenable) && $stable({bus.read, bus.write}));

endmodule

/* hdl/word_ram.sv */
`include "soc_dbus_consts.svh"

module word_ram (
    input  logic clk,
    mem_if.mem   mem
);

    logic [`SOC_DATA_W-1:0] ram_q [`SOC_RAM_WORDS];
    logic [`SOC_DATA_W-1:0] rddata_q;

    always_ff @(posedge clk) begin
        if (mem.write) begin
            ram_q[mem.addr] <= mem.wrdata;
        end
        // Output keeps the last word read until the next read
        if (mem.read) begin
            rddata_q <= ram_q[mem.addr];
        end
    end

    assign mem.rddata = rddata_q;

endmodule

/* hdl/gpio_regs.sv */
`include "soc_dbus_consts.svh"

module gpio_regs (
    input  logic                   clk,
    input  logic                   arst_n_i,
    slave_bus_if.slave             bus,
    output logic [`SOC_DATA_W-1:0] gpio_o
);
    import soc_dbus_pkg::*;

    bus_word_u gpio_q;
    bus_word_u wr_word;
    logic      sel;

    assign sel     = (bus.address[`SOC_ADDR_W-1:2] == '0);  // Only word offset zero exists
    assign wr_word = bus.wrdata;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_q <= '0;
        end else if (bus.write && sel) begin
            for (int i = 0; i < `SOC_BE_W; i++) begin
                if (bus.byteenable[i]) begin
                    gpio_q.bytes[i] <= wr_word.bytes[i];
                end
            end
        end
    end

    assign bus.rddata = (bus.read && sel) ? gpio_q.word : '0;
    assign bus.stall  = 1'b0;  // Register access never waits
    assign gpio_o     = gpio_q.word;

endmodule

/* hdl/soc_dbus_top.sv */
`include "soc_dbus_consts.svh"

module soc_dbus_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [`SOC_ADDR_W-1:0] master_address_i,
    input  logic [`SOC_BE_W-1:0]   master_byteenable_i,
    input  logic                   master_read_i,
    input  logic                   master_write_i,
    input  logic [`SOC_DATA_W-1:0] master_wrdata_i,
    output logic [`SOC_DATA_W-1:0] master_rddata_o,
    output logic                   master_stall_o,
    output logic [`SOC_DATA_W-1:0] gpio_o
);

    slave_bus_if ram_bus ();
    slave_bus_if gpio_bus ();
    mem_if       ram_mem ();

    dbus dbus0 (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_rddata_o     (master_rddata_o),
        .master_stall_o      (master_stall_o),
        .ram_bus             (ram_bus.master),
        .gpio_bus            (gpio_bus.master)
    );

    // Partial writes become read-modify-write on the word RAM
    bytes_conv mem_conv (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (ram_bus.slave),
        .mem      (ram_mem.ctrl)
    );

    word_ram mainram (
        .clk (clk),
        .mem (ram_mem.mem)
    );

    gpio_regs gpio_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (gpio_bus.slave),
        .gpio_o   (gpio_o)
    );

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS    = 8;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        #(RESET_CYCLES * PERIOD_NS);  // Lands on a falling edge, away from the rising one
        arst_n_o = 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* tests/tb_soc_dbus.sv */
`include "soc_dbus_consts.svh"

module tb_soc_dbus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 8;
    localparam int SETTLE_NS     = 2;  // Outputs are sampled this long after the falling edge
    localparam int N_FULL        = 16;
    localparam int N_PART        = 40;
    localparam int N_GPIO        = 8;
    localparam int N_UNMAP       = 4;
    localparam int TOTAL_ACCESSES = 1 + 2 * N_FULL + 2 * N_PART + 2 * N_GPIO + 1
                                  + 2 * N_UNMAP + N_FULL + 1;

    logic                   clk;
    logic                   arst_n;
    logic [`SOC_ADDR_W-1:0] master_address;
    logic [`SOC_BE_W-1:0]   master_byteenable;
    logic                   master_read;
    logic                   master_write;
    logic [`SOC_DATA_W-1:0] master_wrdata;
    logic [`SOC_DATA_W-1:0] master_rddata;
    logic                   master_stall;
    logic [`SOC_DATA_W-1:0] gpio;

    logic [31:0] shadow_ram [`SOC_RAM_WORDS];
    logic [31:0] shadow_gpio;
    int          used_idx [N_FULL];
    logic [31:0] unmapped_addr [N_UNMAP];
    integer      seed;

    tb_clock_gen clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    soc_dbus_top dut (
        .clk                 (clk),
        .arst_n_i            (arst_n),
        .master_address_i    (master_address),
        .master_byteenable_i (master_byteenable),
        .master_read_i       (master_read),
        .master_write_i      (master_write),
        .master_wrdata_i     (master_wrdata),
        .master_rddata_o     (master_rddata),
        .master_stall_o      (master_stall),
        .gpio_o              (gpio)
    );

    // Expected word after a write that only touches the enabled byte lanes
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] ram_addr(input int idx);
        return `SOC_RAM_BASE + idx * 4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One master access held until stall is seen low before a rising edge
    task automatic bus_access(input logic [31:0] addr, input logic [3:0] be,
                              input logic is_write, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int cycles);
        logic done;
        @(negedge clk);
        master_address    = addr;
        master_byteenable = be;
        master_wrdata     = wdata;
        master_read       = !is_write;
        master_write      = is_write;
        cycles            = 0;
        done              = 1'b0;
        rdata             = '0;
        while (!done) begin
            #(SETTLE_NS);
            cycles++;
            if (!master_stall) begin
                done  = 1'b1;
                rdata = master_rddata;
            end
            @(posedge clk);
            if (!done) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        master_read  = 1'b0;
        master_write = 1'b0;
    endtask

    initial begin
        #((TOTAL_ACCESSES * 5 + 13) * CLK_PERIOD_NS);
        $display("Timeout: the bus accesses did not complete in the expected time");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [3:0]  be;
        int          cycles;
        int          idx;

        seed              = 35;
        master_address    = '0;
        master_byteenable = '0;
        master_read       = 1'b0;
        master_write      = 1'b0;
        master_wrdata     = '0;
        shadow_gpio       = '0;
        for (int i = 0; i < N_FULL; i++) begin
            used_idx[i] = (i * 67) % `SOC_RAM_WORDS;  // Distinct words spread over the RAM
        end
        unmapped_addr[0] = 32'h2000_0000;
        unmapped_addr[1] = `SOC_RAM_BASE + `SOC_RAM_BYTES;
        unmapped_addr[2] = `SOC_GPIO_BASE + `SOC_GPIO_BYTES;
        unmapped_addr[3] = 32'hFFFF_FFFC;

        wait (arst_n === 1'b1);
        @(negedge clk);
        #(SETTLE_NS);
        check_value("stall after reset", 32'h0, master_stall);
        bus_access(`SOC_GPIO_BASE, 4'hF, 1'b0, 32'h0, rdata, cycles);
        check_value("gpio read after reset", 32'h0, rdata);
        check_value("gpio_o after reset", 32'h0, gpio);

        for (int i = 0; i < N_FULL; i++) begin
            wdata = $random(seed);
            bus_access(ram_addr(used_idx[i]), 4'hF, 1'b1, wdata, rdata, cycles);
            shadow_ram[used_idx[i]] = wdata;
            check_value("full write cycles", 32'd1, cycles);
        end
        for (int i = 0; i < N_FULL; i++) begin
            bus_access(ram_addr(used_idx[i]), 4'hF, 1'b0, 32'h0, rdata, cycles);
            check_value($sformatf("full read word %0d", used_idx[i]),
                        shadow_ram[used_idx[i]], rdata);
            check_value("full read cycles", 32'd2, cycles);
        end

        // Partial writes only hit words that already hold known data
        for (int i = 0; i < N_PART; i++) begin
            idx = used_idx[$unsigned($random(seed)) % N_FULL];
            do begin
                be = $random(seed);
            end while (be == 4'h0 || be == 4'hF);
            wdata = $random(seed);
            bus_access(ram_addr(idx), be, 1'b1, wdata, rdata, cycles);
            shadow_ram[idx] = merge_bytes(shadow_ram[idx], wdata, be);
            check_value("partial write cycles", 32'd3, cycles);
            bus_access(ram_addr(idx), 4'hF, 1'b0, 32'h0, rdata, cycles);
            check_value($sformatf("partial read word %0d", idx), shadow_ram[idx], rdata);
            check_value("partial read cycles", 32'd2, cycles);
        end

        for (int i = 0; i < N_GPIO; i++) begin
            be    = $random(seed);
            wdata = $random(seed);
            bus_access(`SOC_GPIO_BASE, be, 1'b1, wdata, rdata, cycles);
            shadow_gpio = merge_bytes(shadow_gpio, wdata, be);
            check_value("gpio write cycles", 32'd1, cycles);
            check_value("gpio_o after write", shadow_gpio, gpio);
            bus_access(`SOC_GPIO_BASE, 4'hF, 1'b0, 32'h0, rdata, cycles);
            check_value("gpio read back", shadow_gpio, rdata);
            check_value("gpio read cycles", 32'd1, cycles);
        end
        bus_access(`SOC_GPIO_BASE + 32'h10, 4'hF, 1'b0, 32'h0, rdata, cycles);
        check_value("gpio unused offset", 32'h0, rdata);

        for (int i = 0; i < N_UNMAP; i++) begin
            wdata = $random(seed);
            bus_access(unmapped_addr[i], 4'hF, 1'b1, wdata, rdata, cycles);
            check_value("unmapped write cycles", 32'd1, cycles);
            bus_access(unmapped_addr[i], 4'hF, 1'b0, 32'h0, rdata, cycles);
            check_value($sformatf("unmapped read %h", unmapped_addr[i]), 32'h0, rdata);
            check_value("unmapped read cycles", 32'd1, cycles);
        end
        for (int i = 0; i < N_FULL; i++) begin
            bus_access(ram_addr(used_idx[i]), 4'hF, 1'b0, 32'h0, rdata, cycles);
            check_value($sformatf("ram kept word %0d", used_idx[i]),
                        shadow_ram[used_idx[i]], rdata);
        end
        bus_access(`SOC_GPIO_BASE, 4'hF, 1'b0, 32'h0, rdata, cycles);
        check_value("gpio kept", shadow_gpio, rdata);
        check_value("gpio_o kept", shadow_gpio, gpio);

        $display("Verification passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/soc_dbus_pkg.sv
hdl/slave_bus_if.sv
hdl/mem_if.sv
hdl/dbus.sv
hdl/bytes_conv.sv
hdl/word_ram.sv
hdl/gpio_regs.sv
hdl/soc_dbus_top.sv
tests/tb_clock_gen.sv
tests/tb_soc_dbus.sv

/* Bender.yml */
package:
  name: soc_dbus

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/soc_dbus_pkg.sv
      - hdl/slave_bus_if.sv
      - hdl/mem_if.sv
      - hdl/dbus.sv
      - hdl/bytes_conv.sv
      - hdl/word_ram.sv
      - hdl/gpio_regs.sv
      - hdl/soc_dbus_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_soc_dbus.sv
